//--- verilog/rom_pkg.sv
//**************************************
// ROM subsystem shared definitions
// Region offsets, widths and types
//**************************************

package rom_pkg;

    localparam int SDRAM_AW = 22;
    localparam int DWN_AW   = 25;
    localparam int LINE_W   = 32;

    // Word address into the 16-bit SDRAM
    typedef logic [SDRAM_AW-1:0] sdram_addr_t;

    // Byte address on the download port
    typedef logic [DWN_AW-1:0] dwn_addr_t;

    // Two SDRAM words, lower address in the low half
    typedef logic [LINE_W-1:0] line_t;

    // Byte offsets of the ROM regions, main ROM sits at zero
    localparam logic [SDRAM_AW-1:0] SND_START = 22'h01_0000;
    localparam logic [SDRAM_AW-1:0] SCR_START = 22'h01_8000;
    // 64kB aligned so the bit scramble stays inside the region
    localparam logic [SDRAM_AW-1:0] OBJ_START = 22'h02_0000;

    // Everything from here on goes to the PROMs
    localparam dwn_addr_t PROM_START = 25'h003_0000;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_REQUEST,
        ARB_FILL
    } arb_state_t;

endpackage

//--- verilog/rom_slot_if.sv
//**************************************
// Read slot to arbiter connection
//**************************************

interface rom_slot_if;
    import rom_pkg::*;

    // Slot side
    logic        req;
    sdram_addr_t addr;

    // Arbiter side, strobes only reach the granted slot
    logic        gnt;
    logic        data_dst;
    logic        data_rdy;
    // Half a line per SDRAM word
    logic [$bits(line_t)/2-1:0] data;

    modport slot (
        output req,
        output addr,
        input  gnt,
        input  data_dst,
        input  data_rdy,
        input  data
    );

    modport arb (
        input  req,
        input  addr,
        output gnt,
        output data_dst,
        output data_rdy,
        output data
    );

endinterface

//--- verilog/dwnld_remap.sv
//**************************************
// Download byte remap
// Nibble swap for scroll, address
// scramble for objects
//**************************************

module dwnld_remap (
    input  logic               clk,
    input  rom_pkg::dwn_addr_t ioctl_addr,
    input  logic [7:0]         ioctl_dout,
    input  logic               ioctl_wr,
    output rom_pkg::dwn_addr_t dwn_addr,
    output logic [7:0]         dwn_data,
    output logic               dwn_wr
);
    import rom_pkg::*;

    dwn_addr_t  addr_next;
    logic [7:0] data_next;
    logic       in_scr;
    logic       in_obj;

    assign in_scr = ioctl_addr >= dwn_addr_t'(SCR_START) &&
                    ioctl_addr <  dwn_addr_t'(OBJ_START);
    assign in_obj = ioctl_addr >= dwn_addr_t'(OBJ_START) &&
                    ioctl_addr <  PROM_START;

    always_comb begin
        addr_next = ioctl_addr;
        data_next = ioctl_dout;
        if (in_scr) begin
            data_next = {ioctl_dout[3:0], ioctl_dout[7:4]};
        end
        // Layout expected by the object renderer
        if (in_obj) begin
            addr_next[15]  = ioctl_addr[0];
            addr_next[14]  = ioctl_addr[15];
            addr_next[0]   = ioctl_addr[14];
            addr_next[2:1] = ioctl_addr[5:4];
            addr_next[6:3] = {ioctl_addr[6], ioctl_addr[3:1]};
        end
    end

    always_ff @(posedge clk) begin
        dwn_addr <= addr_next;
        dwn_data <= data_next;
        dwn_wr   <= ioctl_wr;
    end

endmodule

//--- verilog/dwnld_packer.sv
//**************************************
// Download packer
// Byte to masked SDRAM word write,
// PROM bytes go to a strobe
//**************************************

module dwnld_packer (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    input  rom_pkg::dwn_addr_t   dwn_addr,
    input  logic [7:0]           dwn_data,
    input  logic                 dwn_wr,
    input  logic                 sdram_ack,
    output rom_pkg::sdram_addr_t prog_addr,
    output logic [15:0]          prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we
);
    import rom_pkg::*;

    logic is_prom;
    logic wr_word;
    logic hold;

    assign is_prom = dwn_addr >= PROM_START;
    assign wr_word = dwn_wr & downloading & ~is_prom;

    // Offset into the PROM area, otherwise the word address
    assign prog_addr = is_prom ? sdram_addr_t'(dwn_addr - PROM_START) : dwn_addr[22:1];

    // Same byte on both lanes, the mask picks one
    assign prog_data = {dwn_data, dwn_data};

    // Active low, even bytes to the low lane
    assign prog_mask = dwn_addr[0] ? 2'b01 : 2'b10;

    // Write stays up until the SDRAM takes it
    always_ff @(posedge clk) begin
        if (reset) begin
            hold <= 1'b0;
        end else if (sdram_ack) begin
            hold <= 1'b0;
        end else if (wr_word) begin
            hold <= 1'b1;
        end
    end

    assign prog_we = wr_word | hold;
    assign prom_we = dwn_wr & downloading & is_prom;

endmodule

//--- verilog/rom_slot.sv
//**************************************
// ROM read slot
// One cached line, fetched on a miss
//**************************************

module rom_slot #(
    parameter int                   AW     = 16,
    parameter int                   DW     = 8,
    parameter rom_pkg::sdram_addr_t OFFSET = '0
) (
    input  logic          clk,
    input  logic          reset,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    output logic [DW-1:0] dout,
    output logic          ok,
    rom_slot_if.slot      bus
);
    import rom_pkg::*;

    logic [AW-3:0] cur_line;
    logic [AW-3:0] tag;
    logic          valid;
    logic          half;
    logic          fill_done;
    logic          line_match;
    logic          issue;
    line_t         line;

    assign cur_line  = addr[AW-1:2];
    assign fill_done = bus.gnt & bus.data_rdy;

    // The line being filled counts as present on its last cycle
    assign line_match = (valid | fill_done) && (tag == cur_line);
    assign issue      = cs & ~line_match & ~bus.req;

    // Two words per line
    assign bus.addr = OFFSET + sdram_addr_t'({tag, 1'b0});

    always_ff @(posedge clk) begin
        if (reset) begin
            bus.req <= 1'b0;
            valid   <= 1'b0;
            half    <= 1'b0;
            ok      <= 1'b0;
        end else begin
            ok <= cs & line_match;
            if (fill_done) begin
                bus.req <= 1'b0;
                valid   <= 1'b1;
            end else if (issue) begin
                bus.req <= 1'b1;
                valid   <= 1'b0;
                half    <= 1'b0;
            end
            if (bus.gnt && bus.data_dst) begin
                half <= ~half;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            tag <= cur_line;
        end
        // Low word arrives first
        if (bus.gnt && bus.data_dst) begin
            if (half) begin
                line[31:16] <= bus.data;
            end else begin
                line[15:0] <= bus.data;
            end
        end
    end

    generate
        if (DW == 8) begin : g_byte
            assign dout = line[{addr[1:0], 3'b000} +: 8];
        end else begin : g_line
            assign dout = line;
        end
    endgenerate

endmodule

//--- verilog/rom_arbiter.sv
//**************************************
// ROM slot arbiter
// Fixed priority onto the SDRAM port
//**************************************

module rom_arbiter (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 downloading,
    rom_slot_if.arb              scr,
    rom_slot_if.arb              obj,
    rom_slot_if.arb              snd,
    rom_slot_if.arb              main,
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  logic [15:0]          data_read
);
    import rom_pkg::*;

    arb_state_t  state;
    logic [3:0]  reqs;
    logic [3:0]  gnt;
    logic [1:0]  sel;
    logic [1:0]  winner;
    sdram_addr_t win_addr;

    assign reqs = {main.req, snd.req, obj.req, scr.req};

    // Scroll first, main last
    always_comb begin
        if (reqs[0]) begin
            winner = 2'd0;
        end else if (reqs[1]) begin
            winner = 2'd1;
        end else if (reqs[2]) begin
            winner = 2'd2;
        end else begin
            winner = 2'd3;
        end
    end

    always_comb begin
        case (winner)
            2'd0:    win_addr = scr.addr;
            2'd1:    win_addr = obj.addr;
            2'd2:    win_addr = snd.addr;
            default: win_addr = main.addr;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ARB_IDLE;
            sdram_req <= 1'b0;
            sel       <= 2'd0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    // Reads wait while a download owns the SDRAM
                    if (!downloading && reqs != 4'd0) begin
                        state     <= ARB_REQUEST;
                        sdram_req <= 1'b1;
                        sel       <= winner;
                    end
                end
                ARB_REQUEST: begin
                    if (sdram_ack) begin
                        state     <= ARB_FILL;
                        sdram_req <= 1'b0;
                    end
                end
                ARB_FILL: begin
                    if (data_rdy) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == ARB_IDLE) begin
            sdram_addr <= win_addr;
        end
    end

    assign gnt = (state == ARB_IDLE) ? 4'd0 : (4'd1 << sel);

    assign scr.gnt       = gnt[0];
    assign scr.data_dst  = gnt[0] & data_dst;
    assign scr.data_rdy  = gnt[0] & data_rdy;
    assign scr.data      = data_read;

    assign obj.gnt       = gnt[1];
    assign obj.data_dst  = gnt[1] & data_dst;
    assign obj.data_rdy  = gnt[1] & data_rdy;
    assign obj.data      = data_read;

    assign snd.gnt       = gnt[2];
    assign snd.data_dst  = gnt[2] & data_dst;
    assign snd.data_rdy  = gnt[2] & data_rdy;
    assign snd.data      = data_read;

    assign main.gnt      = gnt[3];
    assign main.data_dst = gnt[3] & data_dst;
    assign main.data_rdy = gnt[3] & data_rdy;
    assign main.data     = data_read;

endmodule

//--- verilog/rom_subsys.sv
//**************************************
// ROM subsystem top
// Download path and four read slots
//**************************************

module rom_subsys (
    input  logic                 clk,
    input  logic                 reset,
    // Download port
    input  rom_pkg::dwn_addr_t   ioctl_addr,
    input  logic [7:0]           ioctl_dout,
    input  logic                 ioctl_wr,
    input  logic                 downloading,
    // SDRAM write side
    output rom_pkg::sdram_addr_t prog_addr,
    output logic [15:0]          prog_data,
    output logic [1:0]           prog_mask,
    output logic                 prog_we,
    output logic                 prom_we,
    // SDRAM read side
    output logic                 sdram_req,
    output rom_pkg::sdram_addr_t sdram_addr,
    input  logic                 sdram_ack,
    input  logic                 data_dst,
    input  logic                 data_rdy,
    input  logic [15:0]          data_read,
    // Clients
    input  logic                 scr_cs,
    input  logic [12:0]          scr_addr,
    output logic [31:0]          scr_data,
    output logic                 scr_ok,
    input  logic                 obj_cs,
    input  logic [13:0]          obj_addr,
    output logic [31:0]          obj_data,
    output logic                 obj_ok,
    input  logic                 snd_cs,
    input  logic [12:0]          snd_addr,
    output logic [7:0]           snd_data,
    output logic                 snd_ok,
    input  logic                 main_cs,
    input  logic [15:0]          main_addr,
    output logic [7:0]           main_data,
    output logic                 main_ok
);
    import rom_pkg::*;

    dwn_addr_t  dwn_addr;
    logic [7:0] dwn_data;
    logic       dwn_wr;

    rom_slot_if scr_bus ();
    rom_slot_if obj_bus ();
    rom_slot_if snd_bus ();
    rom_slot_if main_bus ();

    dwnld_remap u_remap (
        .clk        (clk),
        .ioctl_addr (ioctl_addr),
        .ioctl_dout (ioctl_dout),
        .ioctl_wr   (ioctl_wr),
        .dwn_addr   (dwn_addr),
        .dwn_data   (dwn_data),
        .dwn_wr     (dwn_wr)
    );

    dwnld_packer u_packer (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .dwn_addr    (dwn_addr),
        .dwn_data    (dwn_data),
        .dwn_wr      (dwn_wr),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    // Graphics clients address whole lines
    rom_slot #(.AW(15), .DW(32), .OFFSET(sdram_addr_t'(SCR_START >> 1))) u_scr_slot (
        .clk   (clk),
        .reset (reset),
        .cs    (scr_cs),
        .addr  ({scr_addr, 2'b00}),
        .dout  (scr_data),
        .ok    (scr_ok),
        .bus   (scr_bus.slot)
    );

    rom_slot #(.AW(16), .DW(32), .OFFSET(sdram_addr_t'(OBJ_START >> 1))) u_obj_slot (
        .clk   (clk),
        .reset (reset),
        .cs    (obj_cs),
        .addr  ({obj_addr, 2'b00}),
        .dout  (obj_data),
        .ok    (obj_ok),
        .bus   (obj_bus.slot)
    );

    rom_slot #(.AW(13), .DW(8), .OFFSET(sdram_addr_t'(SND_START >> 1))) u_snd_slot (
        .clk   (clk),
        .reset (reset),
        .cs    (snd_cs),
        .addr  (snd_addr),
        .dout  (snd_data),
        .ok    (snd_ok),
        .bus   (snd_bus.slot)
    );

    rom_slot #(.AW(16), .DW(8), .OFFSET('0)) u_main_slot (
        .clk   (clk),
        .reset (reset),
        .cs    (main_cs),
        .addr  (main_addr),
        .dout  (main_data),
        .ok    (main_ok),
        .bus   (main_bus.slot)
    );

    rom_arbiter u_arbiter (
        .clk         (clk),
        .reset       (reset),
        .downloading (downloading),
        .scr         (scr_bus.arb),
        .obj         (obj_bus.arb),
        .snd         (snd_bus.arb),
        .main        (main_bus.arb),
        .sdram_req   (sdram_req),
        .sdram_addr  (sdram_addr),
        .sdram_ack   (sdram_ack),
        .data_dst    (data_dst),
        .data_rdy    (data_rdy),
        .data_read   (data_read)
    );

endmodule

//--- dv/rom_subsys_props.sv
//****************************************
// SDRAM and download strobe assertions
// Bound into the arbiter and the packer
//****************************************

module rom_subsys_props (
    input logic clk,
    input logic reset,
    input logic downloading,
    input logic sdram_req,
    input logic sdram_ack,
    input logic prog_we,
    input logic prom_we
);
    timeunit 1ns;
    timeprecision 1ps;

    // Read request stays up until acknowledged
    req_held: assert property (@(posedge clk) disable iff (reset)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req fell before sdram_ack");

    // Write strobe waits for the ack, then drops
    we_held: assert property (@(posedge clk) disable iff (reset)
        prog_we && !sdram_ack |=> prog_we)
        else $error("prog_we fell before sdram_ack");

    we_drop: assert property (@(posedge clk) disable iff (reset)
        prog_we && sdram_ack |=> !prog_we)
        else $error("prog_we still high the cycle after sdram_ack");

    no_read_dl: assert property (@(posedge clk) disable iff (reset)
        downloading |-> !sdram_req)
        else $error("sdram_req high while downloading");

    prom_pulse: assert property (@(posedge clk) disable iff (reset)
        prom_we |=> !prom_we)
        else $error("prom_we longer than one cycle");

endmodule

bind rom_arbiter rom_subsys_props u_arb_props (
    .clk         (clk),
    .reset       (reset),
    .downloading (downloading),
    .sdram_req   (sdram_req),
    .sdram_ack   (sdram_ack),
    .prog_we     (1'b0),
    .prom_we     (1'b0)
);

bind dwnld_packer rom_subsys_props u_pack_props (
    .clk         (clk),
    .reset       (reset),
    .downloading (downloading),
    .sdram_req   (1'b0),
    .sdram_ack   (sdram_ack),
    .prog_we     (prog_we),
    .prom_we     (prom_we)
);

//--- dv/rom_subsys_tb.sv
//****************************************
// ROM subsystem testbench
// SDRAM model, download and slot reads
//****************************************

module rom_subsys_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import rom_pkg::*;

    localparam int WAIT_LIMIT = 200;
    // Covers main, sound, scroll and object regions
    localparam int MEM_WORDS  = 'h18000;

    logic        clk;
    logic        reset;
    dwn_addr_t   ioctl_addr;
    logic [7:0]  ioctl_dout;
    logic        ioctl_wr;
    logic        downloading;
    sdram_addr_t prog_addr;
    logic [15:0] prog_data;
    logic [1:0]  prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_dst;
    logic        data_rdy;
    logic [15:0] data_read;
    logic        scr_cs;
    logic [12:0] scr_addr;
    logic [31:0] scr_data;
    logic        scr_ok;
    logic        obj_cs;
    logic [13:0] obj_addr;
    logic [31:0] obj_data;
    logic        obj_ok;
    logic        snd_cs;
    logic [12:0] snd_addr;
    logic [7:0]  snd_data;
    logic        snd_ok;
    logic        main_cs;
    logic [15:0] main_addr;
    logic [7:0]  main_data;
    logic        main_ok;

    logic [15:0] sdram_mem [MEM_WORDS];
    logic [15:0] ref_mem [MEM_WORDS];
    sdram_addr_t fetch_q [$];
    int          seed = 66780;
    int          errors = 0;
    int          err_mark = 0;
    int          n_pass = 0;
    int          n_fail = 0;
    string       test_name;

    rom_subsys UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % 32'(n));
    endfunction

    // Expected SDRAM placement of one download byte
    function automatic void ref_map(input dwn_addr_t a, input logic [7:0] d,
                                    output sdram_addr_t waddr, output logic lane,
                                    output logic [7:0] b, output logic prom);
        int        src [16] = '{14, 4, 5, 1, 2, 3, 6, 7, 8, 9, 10, 11, 12, 13, 15, 0};
        dwn_addr_t m;
        m    = a;
        b    = d;
        prom = a >= PROM_START;
        if (a >= dwn_addr_t'(SCR_START) && a < dwn_addr_t'(OBJ_START)) begin
            b = {d[3:0], d[7:4]};
        end else if (a >= dwn_addr_t'(OBJ_START) && !prom) begin
            for (int i = 0; i < 16; i++) begin
                m[i] = a[src[i]];
            end
        end
        waddr = prom ? sdram_addr_t'(a - PROM_START) : m[22:1];
        lane  = m[0];
    endfunction

    function automatic line_t exp_line(input int byte_addr);
        int w;
        w = byte_addr >> 1;
        return {ref_mem[w + 1], ref_mem[w]};
    endfunction

    function automatic logic [7:0] exp_byte(input int byte_addr);
        logic [15:0] word;
        word = ref_mem[byte_addr >> 1];
        return byte_addr[0] ? word[15:8] : word[7:0];
    endfunction

    function automatic sdram_addr_t line_word(input int byte_addr);
        return sdram_addr_t'((byte_addr & ~3) >> 1);
    endfunction

    task automatic report_fail(input string what);
        $display("%s: %s", test_name, what);
        errors++;
    endtask

    task automatic check_addr(input string what, input sdram_addr_t exp, input sdram_addr_t act);
        if (act !== exp) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_word(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_mask(input string what, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp) begin
            $display("ERR %s %s expected %b actual %b", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_line(input string what, input line_t exp, input line_t act);
        if (act !== exp) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        if (errors == err_mark) begin
            $display("PASS %s", test_name);
            n_pass++;
        end else begin
            $display("FAIL %s with %0d errors", test_name, errors - err_mark);
            n_fail++;
        end
    endtask

    // Starts and returns on a falling edge
    task automatic download_byte(input dwn_addr_t a, input logic [7:0] d);
        sdram_addr_t waddr;
        logic        lane;
        logic        prom;
        logic [7:0]  b;
        int          cnt;
        ref_map(a, d, waddr, lane, b, prom);
        ioctl_addr = a;
        ioctl_dout = d;
        ioctl_wr   = 1'b1;
        @(negedge clk);
        ioctl_wr = 1'b0;
        check_addr("prog_addr", waddr, prog_addr);
        if (prom) begin
            if (!prom_we || prog_we) begin
                report_fail("PROM byte did not give a lone prom_we pulse");
            end
            @(negedge clk);
            if (prom_we || prog_we) begin
                report_fail("strobe still high the cycle after a PROM byte");
            end
        end else begin
            if (!prog_we || prom_we) begin
                report_fail("ROM byte did not raise prog_we alone");
            end
            check_word("prog_data", {b, b}, prog_data);
            check_mask("prog_mask", lane ? 2'b01 : 2'b10, prog_mask);
            if (lane) begin
                ref_mem[waddr][15:8] = b;
            end else begin
                ref_mem[waddr][7:0] = b;
            end
            cnt = 0;
            do begin
                @(negedge clk);
                cnt++;
            end while (prog_we && cnt < WAIT_LIMIT);
            if (prog_we) begin
                report_fail("timeout waiting for the SDRAM to take a write");
            end
        end
    endtask

    // Reads on the enabled slots at once
    // lat counts the cycles until every enabled ok is high
    task automatic read_slots(input logic [3:0] en, input logic [12:0] sa,
                              input logic [13:0] oa, input logic [12:0] na,
                              input logic [15:0] ma, output int lat);
        @(negedge clk);
        {main_cs, snd_cs, obj_cs, scr_cs} = en;
        scr_addr  = sa;
        obj_addr  = oa;
        snd_addr  = na;
        main_addr = ma;
        lat = 0;
        do begin
            @(negedge clk);
            lat++;
        end while ((en & {main_ok, snd_ok, obj_ok, scr_ok}) != en && lat < WAIT_LIMIT);
        if ((en & {main_ok, snd_ok, obj_ok, scr_ok}) != en) begin
            report_fail("timeout waiting for slot ok");
        end
        if (en[0]) begin
            check_line("scr_data", exp_line(int'(SCR_START) + 4 * int'(sa)), scr_data);
        end
        if (en[1]) begin
            check_line("obj_data", exp_line(int'(OBJ_START) + 4 * int'(oa)), obj_data);
        end
        if (en[2]) begin
            check_byte("snd_data", exp_byte(int'(SND_START) + int'(na)), snd_data);
        end
        if (en[3]) begin
            check_byte("main_data", exp_byte(int'(ma)), main_data);
        end
        {main_cs, snd_cs, obj_cs, scr_cs} = 4'b0000;
        @(negedge clk);
    endtask

    // SDRAM model serving both the write and the read side
    initial begin
        sdram_addr_t raddr;
        sdram_ack = 1'b0;
        data_dst  = 1'b0;
        data_rdy  = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (prog_we) begin
                repeat (rand_below(4)) @(negedge clk);
                if (int'(prog_addr) < MEM_WORDS) begin
                    if (!prog_mask[0]) begin
                        sdram_mem[prog_addr][7:0] = prog_data[7:0];
                    end
                    if (!prog_mask[1]) begin
                        sdram_mem[prog_addr][15:8] = prog_data[15:8];
                    end
                end
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
            end else if (sdram_req) begin
                repeat (rand_below(4)) @(negedge clk);
                raddr = sdram_addr;
                fetch_q.push_back(raddr);
                sdram_ack = 1'b1;
                @(negedge clk);
                sdram_ack = 1'b0;
                for (int i = 0; i < 2; i++) begin
                    repeat (rand_below(3)) @(negedge clk);
                    data_read = sdram_mem[int'(raddr) + i];
                    data_dst  = 1'b1;
                    @(negedge clk);
                    data_dst  = 1'b0;
                end
                data_rdy = 1'b1;
                @(negedge clk);
                data_rdy = 1'b0;
            end
        end
    end

    initial begin
        int n;
        int lat;
        ioctl_addr  = '0;
        ioctl_dout  = '0;
        ioctl_wr    = 1'b0;
        downloading = 1'b0;
        {scr_cs, obj_cs, snd_cs, main_cs} = 4'b0000;
        scr_addr  = '0;
        obj_addr  = '0;
        snd_addr  = '0;
        main_addr = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            sdram_mem[i] = 16'(i ^ (i >> 4));
            ref_mem[i]   = 16'(i ^ (i >> 4));
        end
        reset = 1'b1;
        repeat (10) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);

        start_test("reset_state");
        if (sdram_req || prog_we || prom_we || scr_ok || obj_ok || snd_ok || main_ok) begin
            report_fail("outputs not low after reset");
        end
        end_test();

        downloading = 1'b1;
        start_test("scroll_download");
        for (int i = 0; i < 8; i++) begin
            download_byte(dwn_addr_t'(SCR_START) + dwn_addr_t'(rand_below('h8000)),
                          8'($random(seed)));
        end
        end_test();

        start_test("object_main_sound_download");
        for (int i = 0; i < 4; i++) begin
            download_byte(dwn_addr_t'(OBJ_START) + dwn_addr_t'(rand_below('h10000)),
                          8'($random(seed)));
        end
        for (int i = 0; i < 2; i++) begin
            download_byte(dwn_addr_t'(rand_below('h10000)), 8'($random(seed)));
            download_byte(dwn_addr_t'(SND_START) + dwn_addr_t'(rand_below('h2000)),
                          8'($random(seed)));
        end
        end_test();

        start_test("prom_download");
        for (int i = 0; i < 4; i++) begin
            download_byte(PROM_START + dwn_addr_t'(rand_below('h1000)), 8'($random(seed)));
        end
        end_test();

        // Image with lines in every region
        // Object bytes are spread by the scramble
        start_test("image_reads");
        for (int i = 0; i < 'h40; i++) begin
            download_byte(dwn_addr_t'(i), 8'($random(seed)));
            download_byte(dwn_addr_t'(SND_START) + dwn_addr_t'(i), 8'($random(seed)));
            download_byte(dwn_addr_t'(SCR_START) + dwn_addr_t'(i), 8'($random(seed)));
            download_byte(dwn_addr_t'(OBJ_START) + dwn_addr_t'(i), 8'($random(seed)));
            download_byte(dwn_addr_t'(OBJ_START) + dwn_addr_t'('h4000 + i), 8'($random(seed)));
        end
        downloading = 1'b0;
        @(negedge clk);
        read_slots(4'b0001, 13'd3, '0, '0, '0, lat);
        read_slots(4'b0010, '0, 14'd5, '0, '0, lat);
        read_slots(4'b0010, '0, 14'h2001, '0, '0, lat);
        read_slots(4'b0100, '0, '0, 13'h13, '0, lat);
        read_slots(4'b1000, '0, '0, '0, 16'h2a, lat);
        end_test();

        start_test("hit_and_miss");
        n = fetch_q.size();
        read_slots(4'b1000, '0, '0, '0, 16'h21, lat);
        read_slots(4'b1000, '0, '0, '0, 16'h22, lat);
        if (fetch_q.size() != n + 1) begin
            report_fail("hit in the cached line caused an SDRAM fetch");
        end
        if (lat != 1) begin
            report_fail("hit did not raise ok on the next cycle");
        end
        read_slots(4'b1000, '0, '0, '0, 16'h35, lat);
        if (fetch_q.size() != n + 2) begin
            report_fail("miss to a new line gave no SDRAM fetch");
        end else begin
            check_addr("fetch_addr", line_word('h21), fetch_q[n]);
            check_addr("fetch_addr", line_word('h35), fetch_q[n + 1]);
        end
        end_test();

        start_test("four_slot_priority");
        n = fetch_q.size();
        read_slots(4'b1111, 13'd7, 14'd9, 13'h3e, 16'h05, lat);
        if (fetch_q.size() != n + 4) begin
            report_fail("four misses did not give four SDRAM fetches");
        end else begin
            check_addr("scr_fetch", line_word(int'(SCR_START) + 28), fetch_q[n]);
            check_addr("obj_fetch", line_word(int'(OBJ_START) + 36), fetch_q[n + 1]);
            check_addr("snd_fetch", line_word(int'(SND_START) + 'h3e), fetch_q[n + 2]);
            check_addr("main_fetch", line_word('h05), fetch_q[n + 3]);
        end
        end_test();

        // A miss raised during a download waits until the download ends
        start_test("read_during_download");
        n = fetch_q.size();
        downloading = 1'b1;
        main_cs     = 1'b1;
        main_addr   = 16'h3c;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            if (sdram_req) begin
                report_fail("sdram_req high while downloading");
            end
        end
        downloading = 1'b0;
        read_slots(4'b1000, '0, '0, '0, 16'h3c, lat);
        if (fetch_q.size() != n + 1) begin
            report_fail("held miss did not give one SDRAM fetch");
        end else begin
            check_addr("fetch_addr", line_word('h3c), fetch_q[n]);
        end
        end_test();

        $display("Tests passed %0d, failed %0d, check errors %0d", n_pass, n_fail, errors);
        if (errors == 0 && n_fail == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- rom_subsys.f
verilog/rom_pkg.sv
verilog/rom_slot_if.sv
verilog/dwnld_remap.sv
verilog/dwnld_packer.sv
verilog/rom_slot.sv
verilog/rom_arbiter.sv
verilog/rom_subsys.sv
dv/rom_subsys_props.sv
dv/rom_subsys_tb.sv

//--- Makefile
TOP = rom_subsys_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f rom_subsys.f --top-module $(TOP) -o $(TOP)

run: compile
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir
